// File: bench/instFetchMmuTb.sv
// Directed testbench for the instruction fetch MMU with a TLB reference model
module instFetchMmuTb;
    timeunit 1ns;
    timeprecision 1ps;

    import mmuPkg::*;

    // ------------------------------
    // Run limits
    // ------------------------------

    // 4 + 5 + 3 + 2 + 4 directed, 8 back-pressure, 40 random
    localparam int NUM_REQUESTS   = 66;
    localparam int TIMEOUT_CYCLES = 40 * NUM_REQUESTS + 100;
    localparam int ACK_WAIT_LIMIT = 8;

    logic      clk;
    logic      rst;
    logic      req;
    vaddrT     vaddr;
    asidT      asid;
    cattrT     k0;
    tlbWriteT  tlbWrite;
    logic      ack;
    fetchRespT resp;

    // Bench copy of the TLB contents
    tlbEntryT    mirror [TLB_ENTRIES];
    logic [31:0] rngState = 32'h70f1_ccae;
    int          cycleCount = 0;
    int          reqCount = 0;

    instFetchMmu u_instFetchMmu (
        .clk       (clk),
        .rst       (rst),
        .reqI      (req),
        .vaddrI    (vaddr),
        .asidI     (asid),
        .k0I       (k0),
        .tlbWriteI (tlbWrite),
        .ackO      (ack),
        .respO     (resp)
    );

    // 4 ns period
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic tlbPageT makePage(input ptagT pfn, input cattrT c, input logic v);
        tlbPageT p;
        p.pfn = pfn;
        p.c   = c;
        p.v   = v;
        return p;
    endfunction

    // Entry covering the page pair of base
    function automatic tlbEntryT makeEntry(input vaddrT base, input asidT id, input logic g,
                                           input tlbPageT ev, input tlbPageT od);
        tlbEntryT e;
        e.vpn2 = base[31:13];
        e.asid = id;
        e.g    = g;
        e.even = ev;
        e.odd  = od;
        return e;
    endfunction

    // Indexed write that lands at the next rising edge
    task automatic writeEntry(input tlbIdxT idx, input tlbEntryT e);
        tlbWrite.valid = 1'b1;
        tlbWrite.index = idx;
        tlbWrite.entry = e;
        @(negedge clk);
        tlbWrite.valid = 1'b0;
        mirror[idx] = e;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic fetchRespT expectedResp(input vaddrT va, input asidT id, input cattrT k0v);
        fetchRespT  r;
        logic [2:0] seg;
        logic       found;
        tlbPageT    pg;
        r     = '0;
        seg   = va[31:29];
        found = 1'b0;
        pg    = '0;
        if ((seg == 3'b100) || (seg == 3'b101)) begin
            r.ptag    = {3'b000, va[28:12]};
            r.unCache = (seg == 3'b101) || (k0v != CATTR_CACHED);
        end else begin
            // First matching entry wins
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (!found && (mirror[i].vpn2 == va[31:13]) &&
                    (mirror[i].g || (mirror[i].asid == id))) begin
                    found = 1'b1;
                    pg    = va[12] ? mirror[i].odd : mirror[i].even;
                end
            end
            // Miss leaves a zero page
            r.ptag    = pg.pfn;
            r.unCache = pg.c != CATTR_CACHED;
            if (!found) begin
                r.hasExc   = 1'b1;
                r.isRefill = 1'b1;
                r.excCode  = EXC_TLBL;
            end else if (!pg.v) begin
                r.hasExc  = 1'b1;
                r.excCode = EXC_TLBL;
            end
        end
        // AdEL overrides any TLB exception
        if (va[1:0] != 2'b00) begin
            r.hasExc   = 1'b1;
            r.isRefill = 1'b0;
            r.excCode  = EXC_ADEL;
        end
        return r;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic checkResp(input fetchRespT got, input fetchRespT exp);
        if (got.ptag !== exp.ptag)
            reportMismatch("respO.ptag", 32'(got.ptag), 32'(exp.ptag));
        if (got.unCache !== exp.unCache)
            reportMismatch("respO.unCache", 32'(got.unCache), 32'(exp.unCache));
        if (got.hasExc !== exp.hasExc)
            reportMismatch("respO.hasExc", 32'(got.hasExc), 32'(exp.hasExc));
        if (got.isRefill !== exp.isRefill)
            reportMismatch("respO.isRefill", 32'(got.isRefill), 32'(exp.isRefill));
        if (got.excCode !== exp.excCode)
            reportMismatch("respO.excCode", 32'(got.excCode), 32'(exp.excCode));
    endtask

    task automatic checkLatency(input int got, input int exp);
        if (got != exp)
            reportMismatch("ackO latency", 32'(got), 32'(exp));
    endtask

    task automatic checkAck(input logic got, input logic exp);
        if (got !== exp)
            reportMismatch("ackO", 32'(got), 32'(exp));
    endtask

    // ------------------------------
    // Fetch request
    // ------------------------------

    // Called at a falling edge with the DUT idle
    task automatic runFetch(input vaddrT va, input asidT id, input cattrT k0v, input int extra);
        fetchRespT expResp;
        int        edges;
        expResp = expectedResp(va, id, k0v);
        vaddr   = va;
        asid    = id;
        k0      = k0v;
        req     = 1'b1;
        edges   = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && (edges < ACK_WAIT_LIMIT));
        if (!ack) begin
            $display("Request for vaddr 0x%08h was never acknowledged", va);
            $display("=== FAIL ===");
            $fatal(1, "handshake stalled");
        end
        checkLatency(edges, 2);
        checkResp(resp, expResp);
        // Response must not move under back-pressure
        repeat (extra) begin
            @(negedge clk);
            checkAck(ack, 1'b1);
            checkResp(resp, expResp);
        end
        req = 1'b0;
        @(negedge clk);
        checkAck(ack, 1'b0);
        // RELEASE back to IDLE
        @(negedge clk);
        reqCount++;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic testUnmapped();
        runFetch(32'h8012_3450, 8'h00, 3'd3, 0);
        runFetch(32'h9fff_f000, 8'h00, 3'd2, 1);
        runFetch(32'ha012_3450, 8'h00, 3'd3, 0);
        runFetch(32'hbfc0_0380, 8'h00, 3'd2, 2);
    endtask

    task automatic testMappedHit();
        writeEntry(4'd0, makeEntry(32'h0040_0000, 8'h00, 1'b1,
                   makePage(20'h12345, 3'd3, 1'b1), makePage(20'h0abcd, 3'd2, 1'b1)));
        writeEntry(4'd1, makeEntry(32'h1000_2000, 8'h11, 1'b0,
                   makePage(20'h54321, 3'd3, 1'b1), makePage(20'h00777, 3'd3, 1'b1)));
        writeEntry(4'd2, makeEntry(32'hc000_4000, 8'h11, 1'b0,
                   makePage(20'hfedcb, 3'd3, 1'b1), makePage(20'h01234, 3'd0, 1'b1)));
        // Shadow copy of entry 0 that the lower index must beat
        writeEntry(4'd4, makeEntry(32'h0040_0000, 8'h00, 1'b1,
                   makePage(20'h99999, 3'd2, 1'b1), makePage(20'h88888, 3'd3, 1'b0)));
        runFetch(32'h0040_0000, 8'h11, 3'd3, 0);
        runFetch(32'h0040_1004, 8'h11, 3'd3, 0);
        // Global entry matches any ASID
        runFetch(32'h0040_0ffc, 8'h55, 3'd3, 0);
        runFetch(32'h1000_2010, 8'h11, 3'd3, 0);
        runFetch(32'hc000_5000, 8'h11, 3'd3, 0);
    endtask

    task automatic testRefill();
        runFetch(32'h0080_0000, 8'h11, 3'd3, 0);
        runFetch(32'hd000_0000, 8'h11, 3'd3, 0);
        // Non-global entry with another ASID
        runFetch(32'h1000_2000, 8'h22, 3'd3, 0);
    endtask

    task automatic testInvalid();
        writeEntry(4'd3, makeEntry(32'h0060_0000, 8'h00, 1'b1,
                   makePage(20'h11111, 3'd3, 1'b0), makePage(20'h22222, 3'd3, 1'b1)));
        runFetch(32'h0060_0100, 8'h00, 3'd3, 0);
        runFetch(32'h0060_1100, 8'h00, 3'd3, 0);
    endtask

    task automatic testMisaligned();
        runFetch(32'h8000_0001, 8'h00, 3'd3, 0);
        runFetch(32'ha000_0002, 8'h00, 3'd3, 0);
        runFetch(32'h0080_0003, 8'h11, 3'd3, 0);
        runFetch(32'h0040_0002, 8'h11, 3'd3, 0);
    endtask

    task automatic testBackPressure();
        for (int e = 0; e < 8; e++) begin
            runFetch(32'h0040_0000 + 32'(e) * 32'h0000_1004, 8'h11, 3'd3, e);
        end
    endtask

    task automatic testRandom();
        tlbEntryT    e;
        vaddrT       va;
        logic [31:0] r;
        logic [31:0] p;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            r      = nextRandom();
            e.vpn2 = r[31:13];
            // Small ASID space so matches happen
            e.asid = {6'b000000, r[1:0]};
            e.g    = r[2];
            p      = nextRandom();
            e.even = makePage(p[31:12], p[4:2], p[0] | p[1]);
            p      = nextRandom();
            e.odd  = makePage(p[31:12], p[4:2], p[0] | p[1]);
            writeEntry(tlbIdxT'(i), e);
        end
        for (int n = 0; n < 40; n++) begin
            r  = nextRandom();
            va = nextRandom();
            // Half reuse a loaded page pair
            if (r[0])
                va[31:13] = mirror[tlbIdxT'(r >> 1)].vpn2;
            // Mostly aligned
            if (r[9] | r[10])
                va[1:0] = 2'b00;
            runFetch(va, {6'b000000, r[12:11]}, r[15:13], int'(r[18:16]));
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clk      = 1'b0;
        rst      = 1'b0;
        req      = 1'b0;
        vaddr    = '0;
        asid     = '0;
        k0       = CATTR_CACHED;
        tlbWrite = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            mirror[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        testUnmapped();
        testMappedHit();
        testRefill();
        testInvalid();
        testMisaligned();
        testBackPressure();
        testRandom();
        $display("Completed %0d requests", reqCount);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: bench/instFetchMmu_properties.sv
// Handshake and response stability assertions bound into the fetch MMU top
module instFetchMmuProperties (
    input logic              clk,
    input logic              rst,
    input logic              reqI,
    input logic              ackI,
    input mmuPkg::fetchRespT respI
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack only ever answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rst)
        $rose(ackI) |-> $past(reqI))
        else $error("ackO rose without reqI");

    // Response frozen through back-pressure
    respHeld: assert property (@(posedge clk) disable iff (!rst)
        (ackI && $past(ackI)) |-> $stable(respI))
        else $error("respO changed while ackO stayed high");

    // Release phase, ack drops one edge after req
    ackDrops: assert property (@(posedge clk) disable iff (!rst)
        (ackI && !reqI) |=> !ackI)
        else $error("ackO did not fall after reqI went low");

    // Clean start out of reset
    ackLowAfterReset: assert property (@(posedge clk)
        $rose(rst) |-> !ackI)
        else $error("ackO high in the first cycle after reset");

endmodule

bind instFetchMmu instFetchMmuProperties u_instFetchMmuProperties (
    .clk   (clk),
    .rst   (rst),
    .reqI  (reqI),
    .ackI  (ackO),
    .respI (respO)
);

// File: instFetchMmu.f
logic/mmuPkg.sv
logic/tlbArray.sv
logic/instTranslate.sv
logic/fetchHandshake.sv
logic/instFetchMmu.sv
bench/instFetchMmu_properties.sv
bench/instFetchMmuTb.sv

// File: logic/fetchHandshake.sv
// Four-phase req/ack controller that sequences capture, lookup and response registration
module fetchHandshake (
    input  logic              clk,
    input  logic              rst,
    // Requester side
    input  logic              reqI,
    output logic              ackO,
    // Translator control
    output logic              captureO,
    input  mmuPkg::fetchRespT respI,
    // Registered response
    output mmuPkg::fetchRespT respO
);
    import mmuPkg::*;

    hsStateT state;
    hsStateT stateNext;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (reqI) begin
                    stateNext = LOOKUP;
                end
            end
            // One cycle for TLB lookup and exception select
            LOOKUP: begin
                stateNext = RESPOND;
            end
            // Hold while the requester keeps req high
            RESPOND: begin
                if (!reqI) begin
                    stateNext = RELEASE;
                end
            end
            RELEASE: begin
                stateNext = IDLE;
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    // Request accepted at the edge that sees req in IDLE
    assign captureO = (state == IDLE) && reqI;

    // ------------------------------
    // State, ack and response
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            ackO  <= 1'b0;
            respO <= '0;
        end else begin
            state <= stateNext;
            if (state == LOOKUP) begin
                // Ack and response rise together
                ackO  <= 1'b1;
                respO <= respI;
            end else if ((state == RESPOND) && !reqI) begin
                ackO  <= 1'b0;
            end
        end
    end

endmodule

// File: logic/instFetchMmu.sv
// Instruction fetch MMU top joining the handshake controller, translator and joint TLB
module instFetchMmu (
    input  logic              clk,
    input  logic              rst,
    // Fetch requester
    input  logic              reqI,
    input  mmuPkg::vaddrT     vaddrI,
    // CP0 state
    input  mmuPkg::asidT      asidI,
    input  mmuPkg::cattrT     k0I,
    // TLBWI stand-in
    input  mmuPkg::tlbWriteT  tlbWriteI,
    // Response
    output logic              ackO,
    output mmuPkg::fetchRespT respO
);
    import mmuPkg::*;

    // Handshake to translator
    logic      capture;
    fetchRespT transResp;

    // Translator to TLB
    vpn2T    tlbVpn2;
    logic    tlbOdd;
    asidT    tlbAsid;
    logic    tlbHit;
    tlbPageT tlbPage;

    fetchHandshake u_fetchHandshake (
        .clk      (clk),
        .rst      (rst),
        .reqI     (reqI),
        .ackO     (ackO),
        .captureO (capture),
        .respI    (transResp),
        .respO    (respO)
    );

    instTranslate u_instTranslate (
        .clk      (clk),
        .rst      (rst),
        .captureI (capture),
        .vaddrI   (vaddrI),
        .asidI    (asidI),
        .k0I      (k0I),
        .tlbVpn2O (tlbVpn2),
        .tlbOddO  (tlbOdd),
        .tlbAsidO (tlbAsid),
        .tlbHitI  (tlbHit),
        .tlbPageI (tlbPage),
        .respO    (transResp)
    );

    tlbArray u_tlbArray (
        .clk    (clk),
        .rst    (rst),
        .writeI (tlbWriteI),
        .vpn2I  (tlbVpn2),
        .oddI   (tlbOdd),
        .asidI  (tlbAsid),
        .hitO   (tlbHit),
        .pageO  (tlbPage)
    );

endmodule

// File: logic/instTranslate.sv
// Instruction address translator with segment decode, TLB query and exception selection
module instTranslate (
    input  logic              clk,
    input  logic              rst,
    // Request capture strobe
    input  logic              captureI,
    input  mmuPkg::vaddrT     vaddrI,
    input  mmuPkg::asidT      asidI,
    input  mmuPkg::cattrT     k0I,
    // TLB query
    output mmuPkg::vpn2T      tlbVpn2O,
    output logic              tlbOddO,
    output mmuPkg::asidT      tlbAsidO,
    // TLB result
    input  logic              tlbHitI,
    input  mmuPkg::tlbPageT   tlbPageI,
    // Combinational response
    output mmuPkg::fetchRespT respO
);
    import mmuPkg::*;

    // Segment class of the captured PC
    logic isKseg0;
    logic isKseg1;
    logic isMapped;

    // kseg0 attribute from Config.K0 at capture
    logic kseg0UnCache;

    // PC not word aligned
    logic misAlign;

    // Captured payload
    ptagT unmapTag;
    vpn2T vpn2Reg;
    logic oddReg;
    asidT asidReg;

    // Mapped page attribute
    logic mappedUnCache;

    // ------------------------------
    // Capture
    // ------------------------------

    // Control flags
    always_ff @(posedge clk) begin
        if (!rst) begin
            isKseg0      <= 1'b0;
            isKseg1      <= 1'b0;
            isMapped     <= 1'b0;
            kseg0UnCache <= 1'b0;
            misAlign     <= 1'b0;
        end else if (captureI) begin
            isKseg0      <= vaddrI[31:29] == SEG_KSEG0;
            isKseg1      <= vaddrI[31:29] == SEG_KSEG1;
            // useg, kseg2 and kseg3 go through the TLB
            isMapped     <= (vaddrI[31:29] != SEG_KSEG0) && (vaddrI[31:29] != SEG_KSEG1);
            kseg0UnCache <= k0I != CATTR_CACHED;
            misAlign     <= vaddrI[1:0] != 2'b00;
        end
    end

    // Address fields and ASID
    always_ff @(posedge clk) begin
        if (captureI) begin
            // Unmapped segments drop the top three bits
            unmapTag <= {3'b000, vaddrI[28:12]};
            vpn2Reg  <= vaddrI[31:13];
            oddReg   <= vaddrI[12];
            asidReg  <= asidI;
        end
    end

    // TLB query from the captured fields
    assign tlbVpn2O = vpn2Reg;
    assign tlbOddO  = oddReg;
    assign tlbAsidO = asidReg;

    // ------------------------------
    // Response
    // ------------------------------

    // Miss returns a zero page, which reads as uncached
    assign mappedUnCache = tlbPageI.c != CATTR_CACHED;

    assign respO.ptag    = isMapped ? tlbPageI.pfn : unmapTag;

    // kseg1 always uncached
    assign respO.unCache = isKseg1 ||
                           (isKseg0 && kseg0UnCache) ||
                           (isMapped && mappedUnCache);

    // AdEL first, then refill and invalid
    always_comb begin
        if (misAlign) begin
            respO.hasExc   = 1'b1;
            respO.isRefill = 1'b0;
            respO.excCode  = EXC_ADEL;
        end else if (isMapped && !(tlbHitI && tlbPageI.v)) begin
            respO.hasExc   = 1'b1;
            // Refill vector only on a true miss
            respO.isRefill = !tlbHitI;
            respO.excCode  = EXC_TLBL;
        end else begin
            respO.hasExc   = 1'b0;
            respO.isRefill = 1'b0;
            respO.excCode  = '0;
        end
    end

endmodule

// File: logic/mmuPkg.sv
// Instruction fetch MMU package with address widths, segment and exception codes, TLB types
package mmuPkg;

    // ------------------------------
    // Address and field widths
    // ------------------------------

    // Virtual PC from the fetch stage
    typedef logic [31:0] vaddrT;
    // Physical address bits 31..12
    typedef logic [19:0] ptagT;
    // Even/odd page pair number, vaddr bits 31..13
    typedef logic [18:0] vpn2T;
    // EntryHi address space ID
    typedef logic [7:0]  asidT;
    // Cache attribute, as in Config.K0 and EntryLo.C
    typedef logic [2:0]  cattrT;
    // Cause.ExcCode width
    typedef logic [4:0]  excCodeT;

    // ------------------------------
    // TLB geometry
    // ------------------------------

    // Joint TLB depth, power of two
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

    typedef logic [TLB_IDX_W-1:0] tlbIdxT;

    // ------------------------------
    // Encodings
    // ------------------------------

    // Cacheable noncoherent
    localparam cattrT   CATTR_CACHED = 3'd3;

    // TLB exception on load or fetch
    localparam excCodeT EXC_TLBL     = 5'd2;
    // Address error on load or fetch
    localparam excCodeT EXC_ADEL     = 5'd4;

    // Top three vaddr bits of the unmapped kernel segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // ------------------------------
    // Structs
    // ------------------------------

    // One 4 KiB page of an entry, EntryLo without the dirty bit
    typedef struct packed {
        ptagT  pfn;
        cattrT c;
        logic  v;
    } tlbPageT;

    // One joint TLB entry covering an even/odd pair
    typedef struct packed {
        vpn2T    vpn2;
        asidT    asid;
        logic    g;
        tlbPageT even;
        tlbPageT odd;
    } tlbEntryT;

    // Indexed write, like TLBWI
    typedef struct packed {
        logic     valid;
        tlbIdxT   index;
        tlbEntryT entry;
    } tlbWriteT;

    // Translation result back to the fetch stage
    typedef struct packed {
        ptagT    ptag;
        logic    unCache;
        logic    hasExc;
        logic    isRefill;
        excCodeT excCode;
    } fetchRespT;

    // Four-phase handshake states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        RELEASE
    } hsStateT;

endpackage

// File: logic/tlbArray.sv
// Joint TLB storage with indexed write port and combinational fully associative lookup
module tlbArray (
    input  logic             clk,
    input  logic             rst,
    // Indexed entry write
    input  mmuPkg::tlbWriteT writeI,
    // Lookup query
    input  mmuPkg::vpn2T     vpn2I,
    input  logic             oddI,
    input  mmuPkg::asidT     asidI,
    // Lookup result
    output logic             hitO,
    output mmuPkg::tlbPageT  pageO
);
    import mmuPkg::*;

    // Entry storage
    tlbEntryT entries [TLB_ENTRIES];

    // One bit per entry that matches the query
    logic [TLB_ENTRIES-1:0] matchVec;

    // Priority encoded winner
    logic     anyHit;
    tlbIdxT   hitIdx;
    tlbEntryT hitEntry;

    // ------------------------------
    // Storage and write port
    // ------------------------------

    // Cleared entries have both pages invalid
    always_ff @(posedge clk) begin
        if (!rst) begin
            entries <= '{default: '0};
        end else if (writeI.valid) begin
            entries[writeI.index] <= writeI.entry;
        end
    end

    // ------------------------------
    // Associative match
    // ------------------------------

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // VPN2 compare, then global or same ASID
            matchVec[i] = (entries[i].vpn2 == vpn2I) &&
                          (entries[i].g || (entries[i].asid == asidI));
        end
    end

    // Scan downwards so the lowest matching index is kept
    always_comb begin
        anyHit = 1'b0;
        hitIdx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                anyHit = 1'b1;
                hitIdx = tlbIdxT'(i);
            end
        end
    end

    assign hitEntry = entries[hitIdx];

    // ------------------------------
    // Page select
    // ------------------------------

    assign hitO = anyHit;

    // Odd page for vaddr bit 12 set, zero page on a miss
    always_comb begin
        if (!anyHit) begin
            pageO = '0;
        end else if (oddI) begin
            pageO = hitEntry.odd;
        end else begin
            pageO = hitEntry.even;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction fetch MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module instFetchMmuTb -Mdir obj_dir -o simv -f instFetchMmu.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
